//--- include/rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// reorder buffer depth, keep it a power of two
`define ROB_SLOTS 8

// data path and pc width
`define DATA_W 16

// fall-through pc increment
`define PC_STEP 2

`endif

//--- design/rob_pkg.sv
`default_nettype none

`include "rob_defines.svh"

package rob_pkg;

	// lc-3b opcode field encodings
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_not  = 4'b1001,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef logic [2:0] lc3b_reg;   // also the nzp mask of a branch
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_nzp;
	typedef logic [$clog2(`ROB_SLOTS)-1:0] rob_tag;

	// what dispatch records about an instruction
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_word pc;
		logic predict;   // predicted taken
	} slot_payload;

	function automatic logic writes_reg(input lc3b_opcode op);
		case (op)
			op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_ldb, op_jsr, op_trap:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- design/rob_slot_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

interface rob_slot_if
	import rob_pkg::*;
();

	logic alloc;        // one cycle, loads payload
	slot_payload payload;

	logic valid;
	logic done;
	logic [`DATA_W-1:0] value;
	slot_payload payload_q;

	logic release_slot; // one cycle, frees the slot at retirement

	modport dispatch (
		output alloc,
		output payload
	);

	modport slot (
		input alloc,
		input payload,
		input release_slot,
		output valid,
		output done,
		output value,
		output payload_q
	);

	modport commit (
		input valid,
		input done,
		input value,
		input payload_q,
		output release_slot
	);

endinterface

`default_nettype wire

//--- design/rob_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_dispatch
	import rob_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input lc3b_opcode issue_opcode,
	input lc3b_reg issue_dest,
	input lc3b_word issue_pc,
	input logic issue_predict,
	output logic issue_ready,
	output rob_tag issue_tag,
	input logic retire,
	input logic flush,
	output logic set_busy,
	output lc3b_reg set_dest,
	output rob_tag set_tag,
	rob_slot_if.dispatch slots [`ROB_SLOTS]
);

	localparam int cnt_w = $clog2(`ROB_SLOTS + 1);
	localparam logic [cnt_w-1:0] full_cnt = cnt_w'(`ROB_SLOTS);

	rob_tag tail;
	logic [cnt_w-1:0] count;
	logic accept;
	slot_payload issue_payload;

	assign issue_ready = (count != full_cnt);
	assign accept = issue_valid && issue_ready && !flush;   // flush cycle drops the issue
	assign issue_tag = tail;

	assign issue_payload = '{opcode: issue_opcode, dest: issue_dest,
		pc: issue_pc, predict: issue_predict};

	for (genvar i = 0; i < `ROB_SLOTS; i++)
	begin : g_alloc
		assign slots[i].alloc = accept && (tail == rob_tag'(i));
		assign slots[i].payload = issue_payload;
	end

	// the new producer owns the destination
	assign set_busy = accept && writes_reg(issue_opcode);
	assign set_dest = issue_dest;
	assign set_tag = tail;

	always_ff @(posedge clk)
	begin
		if (rst || flush)
		begin
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (accept)
				tail <= tail + 1'b1;   // wraps at the slot count
			case ({accept, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// occupancy never wraps past full when commit retires
	a_count_in_range: assert property (@(posedge clk) disable iff (rst)
		count <= full_cnt);

endmodule

`default_nettype wire

//--- design/rob_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_slot
	import rob_pkg::*;
#(
	parameter rob_tag slot_id = '0
)
(
	input logic clk,
	input logic rst,
	input logic cdb_valid,
	input rob_tag cdb_tag,
	input logic [`DATA_W-1:0] cdb_value,
	input logic flush,
	rob_slot_if.slot port
);

	logic cdb_hit;

	// a write to a slot being allocated this cycle is dropped
	assign cdb_hit = cdb_valid && (cdb_tag == slot_id) && port.valid && !port.alloc;

	always_ff @(posedge clk)
	begin
		if (rst || flush || port.release_slot)
		begin
			port.valid <= 1'b0;
			port.done <= 1'b0;
		end
		else if (port.alloc)
		begin
			port.valid <= 1'b1;
			port.done <= 1'b0;
		end
		else if (cdb_hit)
			port.done <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (port.alloc)
			port.payload_q <= port.payload;
		if (cdb_hit)
			port.value <= cdb_value;   // result or branch offset
	end

	// commit only frees a finished head
	a_release_done: assert property (@(posedge clk) disable iff (rst)
		port.release_slot |-> port.valid && port.done);

endmodule

`default_nettype wire

//--- design/commit_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module commit_control
	import rob_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic dmem_resp,
	output logic commit_valid,
	output rob_tag commit_tag,
	output lc3b_opcode commit_opcode,
	output logic dmem_write,
	output logic [`DATA_W-1:0] dmem_wdata,
	output logic pcmux_sel,
	output lc3b_word new_pc,
	output logic flush,
	output logic retire,
	output logic wr_en,
	output lc3b_reg wr_dest,
	output logic [`DATA_W-1:0] wr_value,
	output rob_tag wr_tag,
	output logic [31:0] branch_count,
	output logic [31:0] mispredict_count,
	rob_slot_if.commit slots [`ROB_SLOTS]
);

	rob_tag head;
	lc3b_nzp cc;
	lc3b_nzp cc_next;
	logic ld_cc;

	logic [`ROB_SLOTS-1:0] valid_vec;
	logic [`ROB_SLOTS-1:0] done_vec;
	logic [`DATA_W-1:0] value_arr [`ROB_SLOTS];
	slot_payload pl_arr [`ROB_SLOTS];

	slot_payload head_pl;
	logic [`DATA_W-1:0] head_val;
	logic head_ready;
	logic taken;
	logic mispredict;
	lc3b_word step_pc;
	lc3b_word taken_pc;

	for (genvar i = 0; i < `ROB_SLOTS; i++)
	begin : g_head
		assign valid_vec[i] = slots[i].valid;
		assign done_vec[i] = slots[i].done;
		assign value_arr[i] = slots[i].value;
		assign pl_arr[i] = slots[i].payload_q;
		assign slots[i].release_slot = retire && (head == rob_tag'(i));
	end

	assign head_pl = pl_arr[head];
	assign head_val = value_arr[head];
	assign head_ready = valid_vec[head] && done_vec[head];

	// branch dest field holds the nzp mask
	assign taken = |(head_pl.dest & cc);
	assign mispredict = (taken != head_pl.predict);
	assign step_pc = head_pl.pc + lc3b_word'(`PC_STEP);
	assign taken_pc = head_pl.pc + head_val;

	assign commit_valid = retire;
	assign commit_tag = head;
	assign commit_opcode = head_pl.opcode;
	assign dmem_wdata = head_val;
	assign wr_dest = head_pl.dest;
	assign wr_tag = head;   // regfile drops busy only if this still matches

	always_comb
	begin
		retire = 1'b0;
		wr_en = 1'b0;
		ld_cc = 1'b0;
		dmem_write = 1'b0;
		pcmux_sel = 1'b0;
		flush = 1'b0;
		new_pc = '0;
		wr_value = head_val;
		if (head_ready)
		begin
			case (head_pl.opcode)
				op_br:
				begin
					retire = 1'b1;
					new_pc = taken ? taken_pc : step_pc;
					pcmux_sel = mispredict;
					flush = mispredict;
				end
				op_str, op_stb:
				begin
					dmem_write = 1'b1;
					retire = dmem_resp;   // held until memory answers
				end
				op_trap:
				begin
					retire = 1'b1;
					wr_en = 1'b1;
					ld_cc = 1'b1;
					wr_value = step_pc;   // return address
					pcmux_sel = 1'b1;
					flush = 1'b1;
					new_pc = head_val;    // trap vector from the bus
				end
				default:
				begin
					retire = 1'b1;
					wr_en = writes_reg(head_pl.opcode);
					ld_cc = wr_en && (head_pl.opcode != op_jsr);
				end
			endcase
		end
	end

	// n, z or p of what is written
	always_comb
	begin
		if (wr_value[`DATA_W-1])
			cc_next = 3'b100;
		else if (wr_value == '0)
			cc_next = 3'b010;
		else
			cc_next = 3'b001;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head <= '0;
			cc <= '0;
			branch_count <= '0;
			mispredict_count <= '0;
		end
		else
		begin
			if (flush)
				head <= '0;
			else if (retire)
				head <= head + 1'b1;
			if (ld_cc)
				cc <= cc_next;
			if (retire && head_pl.opcode == op_br)
			begin
				branch_count <= branch_count + 1'b1;
				if (mispredict)
					mispredict_count <= mispredict_count + 1'b1;
			end
		end
	end

	// a flush retires its instruction and empties every slot
	a_flush_empties: assert property (@(posedge clk) disable iff (rst)
		flush |-> commit_valid ##1 (valid_vec == '0));

	// store data stays put while the memory stalls
	a_store_stable: assert property (@(posedge clk) disable iff (rst)
		(dmem_write && !dmem_resp) |=> dmem_write && $stable(dmem_wdata));

endmodule

`default_nettype wire

//--- design/arch_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module arch_regfile
	import rob_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic flush,
	input logic set_busy,
	input lc3b_reg set_dest,
	input rob_tag set_tag,
	input logic wr_en,
	input lc3b_reg wr_dest,
	input logic [`DATA_W-1:0] wr_value,
	input rob_tag wr_tag,
	input lc3b_reg rd_sel,
	output logic [`DATA_W-1:0] rd_value,
	output logic rd_busy
);

	logic [`DATA_W-1:0] regs [8];
	logic [7:0] busy;
	rob_tag tags [8];   // youngest producer per register

	always_ff @(posedge clk)
	begin
		if (wr_en)
			regs[wr_dest] <= wr_value;
	end

	always_ff @(posedge clk)
	begin
		if (rst || flush)
			busy <= '0;
		else
		begin
			// a younger producer keeps the register busy
			if (wr_en && busy[wr_dest] && tags[wr_dest] == wr_tag)
				busy[wr_dest] <= 1'b0;
			if (set_busy)
				busy[set_dest] <= 1'b1;   // last assignment wins
		end
	end

	always_ff @(posedge clk)
	begin
		if (set_busy)
			tags[set_dest] <= set_tag;
	end

	assign rd_value = regs[rd_sel];
	assign rd_busy = busy[rd_sel];

endmodule

`default_nettype wire

//--- design/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_top
	import rob_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic issue_valid,
	input lc3b_opcode issue_opcode,
	input lc3b_reg issue_dest,
	input lc3b_word issue_pc,
	input logic issue_predict,
	output logic issue_ready,
	output rob_tag issue_tag,
	input logic cdb_valid,
	input rob_tag cdb_tag,
	input logic [`DATA_W-1:0] cdb_value,
	input logic dmem_resp,
	output logic commit_valid,
	output rob_tag commit_tag,
	output lc3b_opcode commit_opcode,
	output logic dmem_write,
	output logic [`DATA_W-1:0] dmem_wdata,
	output logic pcmux_sel,
	output lc3b_word new_pc,
	output logic flush,
	output logic [31:0] branch_count,
	output logic [31:0] mispredict_count,
	input lc3b_reg rd_sel,
	output logic [`DATA_W-1:0] rd_value,
	output logic rd_busy
);

	logic retire;
	logic set_busy;
	lc3b_reg set_dest;
	rob_tag set_tag;
	logic wr_en;
	lc3b_reg wr_dest;
	logic [`DATA_W-1:0] wr_value;
	rob_tag wr_tag;

	rob_slot_if slot_bus [`ROB_SLOTS] ();

	rob_dispatch i_dispatch (
		.clk,
		.rst,
		.issue_valid,
		.issue_opcode,
		.issue_dest,
		.issue_pc,
		.issue_predict,
		.issue_ready,
		.issue_tag,
		.retire,
		.flush,
		.set_busy,
		.set_dest,
		.set_tag,
		.slots(slot_bus)
	);

	for (genvar i = 0; i < `ROB_SLOTS; i++)
	begin : g_slot
		rob_slot #(.slot_id(rob_tag'(i))) i_slot (
			.clk,
			.rst,
			.cdb_valid,
			.cdb_tag,
			.cdb_value,
			.flush,
			.port(slot_bus[i])
		);
	end

	commit_control i_commit (
		.clk,
		.rst,
		.dmem_resp,
		.commit_valid,
		.commit_tag,
		.commit_opcode,
		.dmem_write,
		.dmem_wdata,
		.pcmux_sel,
		.new_pc,
		.flush,
		.retire,
		.wr_en,
		.wr_dest,
		.wr_value,
		.wr_tag,
		.branch_count,
		.mispredict_count,
		.slots(slot_bus)
	);

	arch_regfile i_regfile (
		.clk,
		.rst,
		.flush,
		.set_busy,
		.set_dest,
		.set_tag,
		.wr_en,
		.wr_dest,
		.wr_value,
		.wr_tag,
		.rd_sel,
		.rd_value,
		.rd_busy
	);

endmodule

`default_nettype wire

//--- dv/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_defines.svh"

module rob_tb
	import rob_pkg::*;
();

	logic clk;
	logic rst;
	logic issue_valid;
	lc3b_opcode issue_opcode;
	lc3b_reg issue_dest;
	lc3b_word issue_pc;
	logic issue_predict;
	logic issue_ready;
	rob_tag issue_tag;
	logic cdb_valid;
	rob_tag cdb_tag;
	lc3b_word cdb_value;
	logic dmem_resp;
	logic commit_valid;
	rob_tag commit_tag;
	lc3b_opcode commit_opcode;
	logic dmem_write;
	lc3b_word dmem_wdata;
	logic pcmux_sel;
	lc3b_word new_pc;
	logic flush;
	logic [31:0] branch_count;
	logic [31:0] mispredict_count;
	lc3b_reg rd_sel;
	lc3b_word rd_value;
	logic rd_busy;

	// one in-flight instruction as the model sees it
	typedef struct packed {
		rob_tag tag;
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_word pc;
		logic predict;
		logic done;
		lc3b_word value;
	} model_entry;

	model_entry q [$];          // oldest first
	lc3b_word regs_model [8];
	logic [7:0] known;          // register written at least once
	logic [7:0] busy_model;
	rob_tag busy_tag [8];
	lc3b_nzp cc_model;
	rob_tag tail_model;
	logic [31:0] branches;
	logic [31:0] mispredicts;
	int mismatches;
	int timeouts;

	rob_top i_rob_top (
		.clk,
		.rst,
		.issue_valid,
		.issue_opcode,
		.issue_dest,
		.issue_pc,
		.issue_predict,
		.issue_ready,
		.issue_tag,
		.cdb_valid,
		.cdb_tag,
		.cdb_value,
		.dmem_resp,
		.commit_valid,
		.commit_tag,
		.commit_opcode,
		.dmem_write,
		.dmem_wdata,
		.pcmux_sel,
		.new_pc,
		.flush,
		.branch_count,
		.mispredict_count,
		.rd_sel,
		.rd_value,
		.rd_busy
	);

	always #50 clk = ~clk;

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_tag(input string what, input rob_tag got, input rob_tag exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_commit(input rob_tag got_tag, input lc3b_opcode got_op,
		input rob_tag exp_tag, input lc3b_opcode exp_op);
		if (got_tag !== exp_tag || got_op !== exp_op)
		begin
			$display("MISMATCH at %0t: commit tag %0d opcode %h, expected tag %0d opcode %h",
				$time, got_tag, got_op, exp_tag, exp_op);
			mismatches++;
		end
	endtask

	task automatic check_word(input string what, input lc3b_word got, input lc3b_word exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_count(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			mismatches++;
		end
	endtask

	// lc-3b instructions that leave a result in a register
	function automatic logic dest_written(input lc3b_opcode op);
		return op inside {op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_ldb,
			op_jsr, op_trap};
	endfunction

	function automatic lc3b_nzp nzp_of(input lc3b_word v);
		if (v[15])
			return 3'b100;
		if (v == 16'h0000)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic lc3b_opcode pick_opcode(input int r);
		case (r % 11)
			0: return op_br;
			1: return op_add;
			2: return op_and;
			3: return op_not;
			4: return op_shf;
			5: return op_lea;
			6: return op_ldr;
			7: return op_ldb;
			8: return op_jsr;
			9: return op_str;
			default: return op_stb;
		endcase
	endfunction

	// compare this cycle's outputs, then advance the model over the coming edge
	task automatic step_model();
		model_entry head;
		model_entry e;
		logic exp_store;
		logic exp_commit;
		logic exp_flush;
		logic accept;
		logic taken;
		lc3b_word result;
		int k;
		head = '0;
		exp_flush = 1'b0;
		if (q.size() > 0)
			head = q[0];
		exp_store = head.done && (head.opcode == op_str || head.opcode == op_stb);
		exp_commit = head.done && (!exp_store || dmem_resp);
		check_flag("issue_ready", issue_ready, q.size() < `ROB_SLOTS);
		check_tag("issue_tag", issue_tag, tail_model);
		check_flag("commit_valid", commit_valid, exp_commit);
		check_flag("dmem_write", dmem_write, exp_store);
		if (exp_store)
			check_word("dmem_wdata", dmem_wdata, head.value);
		if (exp_commit)
		begin
			check_commit(commit_tag, commit_opcode, head.tag, head.opcode);
			if (head.opcode == op_br)
			begin
				taken = |(head.dest & cc_model);   // dest holds the nzp mask
				exp_flush = (taken != head.predict);
				check_word("branch new_pc", new_pc,
					taken ? head.pc + head.value : head.pc + 16'(`PC_STEP));
				branches++;
				if (exp_flush)
					mispredicts++;
			end
			else if (head.opcode == op_trap)
			begin
				exp_flush = 1'b1;
				check_word("trap vector", new_pc, head.value);
			end
		end
		check_flag("flush", flush, exp_flush);
		check_flag("pcmux_sel", pcmux_sel, exp_flush);
		check_flag("rd_busy", rd_busy, busy_model[rd_sel]);
		if (known[rd_sel])
			check_word("rd_value", rd_value, regs_model[rd_sel]);

		accept = issue_valid && (q.size() < `ROB_SLOTS) && !exp_flush;
		if (exp_commit)
		begin
			e = q.pop_front();
			if (dest_written(e.opcode))
			begin
				result = (e.opcode == op_trap) ? e.pc + 16'(`PC_STEP) : e.value;
				regs_model[e.dest] = result;
				known[e.dest] = 1'b1;
				if (e.opcode != op_jsr)
					cc_model = nzp_of(result);
				if (busy_model[e.dest] && busy_tag[e.dest] == e.tag)
					busy_model[e.dest] = 1'b0;
			end
		end
		if (cdb_valid)
		begin
			for (k = 0; k < q.size(); k++)
			begin
				if (q[k].tag == cdb_tag)
				begin
					e = q[k];
					e.done = 1'b1;
					e.value = cdb_value;
					q[k] = e;
				end
			end
		end
		if (accept)
		begin
			e = '{tag: tail_model, opcode: issue_opcode, dest: issue_dest, pc: issue_pc,
				predict: issue_predict, done: 1'b0, value: 16'h0000};
			q.push_back(e);
			if (dest_written(issue_opcode))
			begin
				busy_model[issue_dest] = 1'b1;   // younger producer takes over
				busy_tag[issue_dest] = tail_model;
			end
			tail_model = tail_model + 1'b1;
		end
		if (exp_flush)
		begin
			q.delete();
			tail_model = '0;
			busy_model = '0;
		end
	endtask

	task automatic drive_inputs(input logic allow_issue);
		int pending [$];
		int k;
		int r;
		for (k = 0; k < q.size(); k++)
		begin
			if (!q[k].done)
				pending.push_back(k);
		end
		r = $urandom_range(0, 31);
		issue_valid <= allow_issue && (q.size() < `ROB_SLOTS) && ($urandom_range(0, 3) != 0);
		issue_opcode <= (r == 0) ? op_trap : pick_opcode(r);   // traps kept rare
		issue_dest <= lc3b_reg'($urandom_range(0, 7));
		issue_pc <= lc3b_word'($urandom) & 16'hfffe;
		issue_predict <= 1'($urandom_range(0, 1));
		if (pending.size() > 0 && $urandom_range(0, 1) == 1)
		begin
			k = pending[$urandom_range(0, pending.size() - 1)];
			cdb_valid <= 1'b1;
			cdb_tag <= q[k].tag;
			cdb_value <= lc3b_word'($urandom);
		end
		else
			cdb_valid <= 1'b0;
		dmem_resp <= ($urandom_range(0, 2) == 0);
		rd_sel <= lc3b_reg'($urandom_range(0, 7));
	endtask

	initial
	begin
		int cyc;
		int drain;
		void'($urandom(93));
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_opcode = op_add;
		issue_dest = '0;
		issue_pc = '0;
		issue_predict = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		dmem_resp = 1'b0;
		rd_sel = '0;
		known = '0;
		busy_model = '0;
		cc_model = '0;
		tail_model = '0;
		branches = '0;
		mispredicts = '0;
		mismatches = 0;
		timeouts = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_count("branch_count after reset", branch_count, 32'd0);
		check_count("mispredict_count after reset", mispredict_count, 32'd0);
		for (cyc = 0; cyc < 3000; cyc++)
		begin
			step_model();
			@(posedge clk);
			drive_inputs(1'b1);
			@(negedge clk);
		end
		// no more issue, let everything in flight retire
		drain = 0;
		while (q.size() != 0 && drain < 500)
		begin
			step_model();
			@(posedge clk);
			drive_inputs(1'b0);
			@(negedge clk);
			drain++;
		end
		if (q.size() != 0)
		begin
			$display("timeout: the reorder buffer still held %0d entries after draining",
				q.size());
			timeouts++;
		end
		step_model();
		check_count("branch_count", branch_count, branches);
		check_count("mispredict_count", mispredict_count, mispredicts);
		$display("branches %0d, mispredicts %0d, mismatches %0d, timeouts %0d",
			branches, mispredicts, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
design/rob_pkg.sv
design/rob_slot_if.sv
design/rob_dispatch.sv
design/rob_slot.sv
design/commit_control.sv
design/arch_regfile.sv
design/rob_top.sv
dv/rob_tb.sv
